//--- Makefile
TOP = rvex_execute_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rvex_execute_top -f rvex_execute.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rvex_execute.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "No errors" > /dev/null

clean:
	rm -rf obj_dir

//--- rvex_exec_csr.sv
`include "rvex_execute_settings.svh"

module rvex_exec_csr
  (input logic clk_i
   , input logic arst_n_i

   , input logic psel_i
   , input logic penable_i
   , input logic pwrite_i
   , input logic [`RVEX_APB_AW-1:0] paddr_i
   , input logic [`RVEX_XLEN-1:0] pwdata_i
   , output logic [`RVEX_XLEN-1:0] prdata_o
   , output logic pready_o
   , output logic pslverr_o

   , output logic hold_o
   , input logic exec_evt_i
   , input logic redir_evt_i
   );

  logic access;
  logic wr;
  logic addr_ok;
  logic hold;
  logic [`RVEX_CNT_W-1:0] exec_cnt;
  logic [`RVEX_CNT_W-1:0] redir_cnt;

  function automatic logic [`RVEX_CNT_W-1:0] sat_inc(input logic [`RVEX_CNT_W-1:0] cnt,
                                                      input logic evt);
    return (evt && (cnt != '1)) ? cnt + 1'b1 : cnt;
  endfunction

  assign access = psel_i & penable_i;
  assign wr = access & pwrite_i;
  assign pready_o = 1'b1;  // zero wait states

  assign addr_ok = (paddr_i == rvex_exec_pkg::rvex_csr_ctrl_c)
                 | (paddr_i == rvex_exec_pkg::rvex_csr_exec_cnt_c)
                 | (paddr_i == rvex_exec_pkg::rvex_csr_redir_cnt_c);
  assign pslverr_o = access & ~addr_ok;

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      rvex_exec_pkg::rvex_csr_ctrl_c:      prdata_o[0] = hold;
      rvex_exec_pkg::rvex_csr_exec_cnt_c:  prdata_o[`RVEX_CNT_W-1:0] = exec_cnt;
      rvex_exec_pkg::rvex_csr_redir_cnt_c: prdata_o[`RVEX_CNT_W-1:0] = redir_cnt;
      default:                             prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold      <= 1'b0;
      exec_cnt  <= '0;
      redir_cnt <= '0;
    end else begin
      if (wr && paddr_i == rvex_exec_pkg::rvex_csr_ctrl_c) hold <= pwdata_i[0];

      // any write clears, write beats a same-cycle event
      if (wr && paddr_i == rvex_exec_pkg::rvex_csr_exec_cnt_c) exec_cnt <= '0;
      else exec_cnt <= sat_inc(exec_cnt, exec_evt_i);

      if (wr && paddr_i == rvex_exec_pkg::rvex_csr_redir_cnt_c) redir_cnt <= '0;
      else redir_cnt <= sat_inc(redir_cnt, redir_evt_i);
    end
  end

  assign hold_o = hold;

  a_apb_enable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_i |-> psel_i);

endmodule : rvex_exec_csr

//--- rvex_exec_pkg.sv
`include "rvex_execute_settings.svh"

package rvex_exec_pkg;

  // decoded instruction entering execute
  typedef struct packed {
    logic                  valid;
    logic                  br_v;
    logic                  jmp_v;
    logic                  imm_v;
    logic                  addpc_v;
    logic                  dmem_r_v;
    logic                  dmem_w_v;
    logic                  rd_w_v;
    logic [`RVEX_XLEN-1:0] pc;
    logic [4:0]            rd;
    logic [2:0]            funct3;
    logic                  alt;     // funct7[5]
    logic [`RVEX_XLEN-1:0] imm;
    logic [`RVEX_XLEN-1:0] rs1_data;
    logic [`RVEX_XLEN-1:0] rs2_data;
  } rvex_execute_cword;

  // word handed to the memory stage
  typedef struct packed {
    logic                  valid;
    logic [4:0]            rd;
    logic                  rd_w_v;
    logic                  dmem_r_v;
    logic                  dmem_w_v;
    logic [`RVEX_XLEN-1:0] result;  // alu result, also redirect target
    logic [`RVEX_XLEN-1:0] store_data;
    logic                  redirect_v;
  } rvex_memory_cword;

  typedef enum logic [1:0] {
    rvex_amux_rs1     = 2'd0,
    rvex_amux_mem_fwd = 2'd1,
    rvex_amux_wb_fwd  = 2'd2,
    rvex_amux_pc      = 2'd3
  } rvex_amux_sel_e;

  typedef enum logic [1:0] {
    rvex_bmux_rs2     = 2'd0,
    rvex_bmux_mem_fwd = 2'd1,
    rvex_bmux_wb_fwd  = 2'd2,
    rvex_bmux_imm     = 2'd3
  } rvex_bmux_sel_e;

  localparam logic [`RVEX_APB_AW-1:0] rvex_csr_ctrl_c      = 'h0;
  localparam logic [`RVEX_APB_AW-1:0] rvex_csr_exec_cnt_c  = 'h4;
  localparam logic [`RVEX_APB_AW-1:0] rvex_csr_redir_cnt_c = 'h8;

endpackage : rvex_exec_pkg

//--- rvex_execute.f
+incdir+.
rvex_isa_pkg.sv
rvex_exec_pkg.sv
rvex_execute_ctl.sv
rvex_execute_dp.sv
rvex_execute_stage.sv
rvex_exec_csr.sv
rvex_execute_top.sv
rvex_execute_tb.sv

//--- rvex_execute_ctl.sv
module rvex_execute_ctl
  (input logic stall_i
   , input logic flush_i

   , input logic imm_v_i
   , input logic addpc_v_i
   , input logic dmem_r_v_i
   , input logic dmem_w_v_i
   , input logic jmp_v_i

   , input logic fwd_mem_rs1_v_i
   , input logic fwd_mem_rs2_v_i
   , input logic fwd_wb_rs1_v_i
   , input logic fwd_wb_rs2_v_i

   , output rvex_exec_pkg::rvex_amux_sel_e amux_sel_o
   , output rvex_exec_pkg::rvex_bmux_sel_e bmux_sel_o
   , output logic [1:0] comp_a_sel_o
   , output logic [1:0] comp_b_sel_o
   , output logic add_override_v_o
   , output logic load_nop_o
   , output logic cword_w_v_o
   );

  rvex_exec_pkg::rvex_amux_sel_e a_fwd;
  rvex_exec_pkg::rvex_bmux_sel_e b_fwd;

  // memory stage is younger, so it wins
  always_comb begin
    if (fwd_mem_rs1_v_i) a_fwd = rvex_exec_pkg::rvex_amux_mem_fwd;
    else if (fwd_wb_rs1_v_i) a_fwd = rvex_exec_pkg::rvex_amux_wb_fwd;
    else a_fwd = rvex_exec_pkg::rvex_amux_rs1;

    if (fwd_mem_rs2_v_i) b_fwd = rvex_exec_pkg::rvex_bmux_mem_fwd;
    else if (fwd_wb_rs2_v_i) b_fwd = rvex_exec_pkg::rvex_bmux_wb_fwd;
    else b_fwd = rvex_exec_pkg::rvex_bmux_rs2;
  end

  assign amux_sel_o = addpc_v_i ? rvex_exec_pkg::rvex_amux_pc : a_fwd;
  assign bmux_sel_o = imm_v_i ? rvex_exec_pkg::rvex_bmux_imm : b_fwd;
  assign comp_a_sel_o = a_fwd;  // comparator never sees pc / imm
  assign comp_b_sel_o = b_fwd;

  // address calc for ld/st, pc+imm for auipc and jumps
  assign add_override_v_o = dmem_r_v_i | dmem_w_v_i | addpc_v_i | jmp_v_i;

  assign load_nop_o = flush_i;
  assign cword_w_v_o = flush_i | ~stall_i;  // flush beats stall

endmodule : rvex_execute_ctl

//--- rvex_execute_dp.sv
`include "rvex_execute_settings.svh"

module rvex_execute_dp
  (input rvex_exec_pkg::rvex_amux_sel_e amux_sel_i
   , input rvex_exec_pkg::rvex_bmux_sel_e bmux_sel_i
   , input logic [1:0] comp_a_sel_i
   , input logic [1:0] comp_b_sel_i
   , input logic add_override_v_i

   , input logic [2:0] funct3_i
   , input logic alt_i
   , input logic [`RVEX_XLEN-1:0] pc_i
   , input logic [`RVEX_XLEN-1:0] imm_i
   , input logic [`RVEX_XLEN-1:0] rs1_data_i
   , input logic [`RVEX_XLEN-1:0] rs2_data_i
   , input logic [`RVEX_XLEN-1:0] mem_rd_data_i
   , input logic [`RVEX_XLEN-1:0] wb_rd_data_i

   , output logic [`RVEX_XLEN-1:0] alu_result_o
   , output logic [`RVEX_XLEN-1:0] store_data_o
   , output logic bru_result_o
   );

  localparam int shamt_w = $clog2(`RVEX_XLEN);

  logic [`RVEX_XLEN-1:0] op_a;
  logic [`RVEX_XLEN-1:0] op_b;
  logic [`RVEX_XLEN-1:0] cmp_a;
  logic [`RVEX_XLEN-1:0] cmp_b;
  logic [shamt_w-1:0] shamt;
  logic lt_s;
  logic lt_u;
  rvex_isa_pkg::rvex_alu_op_e alu_op;

  always_comb begin
    case (amux_sel_i)
      rvex_exec_pkg::rvex_amux_mem_fwd: op_a = mem_rd_data_i;
      rvex_exec_pkg::rvex_amux_wb_fwd:  op_a = wb_rd_data_i;
      rvex_exec_pkg::rvex_amux_pc:      op_a = pc_i;
      default:                          op_a = rs1_data_i;
    endcase

    case (bmux_sel_i)
      rvex_exec_pkg::rvex_bmux_mem_fwd: op_b = mem_rd_data_i;
      rvex_exec_pkg::rvex_bmux_wb_fwd:  op_b = wb_rd_data_i;
      rvex_exec_pkg::rvex_bmux_imm:     op_b = imm_i;
      default:                          op_b = rs2_data_i;
    endcase

    // comparator operands, forwarded register values only
    case (comp_a_sel_i)
      rvex_exec_pkg::rvex_amux_mem_fwd: cmp_a = mem_rd_data_i;
      rvex_exec_pkg::rvex_amux_wb_fwd:  cmp_a = wb_rd_data_i;
      default:                          cmp_a = rs1_data_i;
    endcase

    case (comp_b_sel_i)
      rvex_exec_pkg::rvex_bmux_mem_fwd: cmp_b = mem_rd_data_i;
      rvex_exec_pkg::rvex_bmux_wb_fwd:  cmp_b = wb_rd_data_i;
      default:                          cmp_b = rs2_data_i;
    endcase
  end

  assign store_data_o = cmp_b;

  assign alu_op = rvex_isa_pkg::rvex_alu_op_e'(funct3_i);
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    alu_result_o = op_a + op_b;
    if (!add_override_v_i) begin
      case (alu_op)
        rvex_isa_pkg::rvex_alu_add:  alu_result_o = alt_i ? op_a - op_b : op_a + op_b;
        rvex_isa_pkg::rvex_alu_sll:  alu_result_o = op_a << shamt;
        rvex_isa_pkg::rvex_alu_slt:
          alu_result_o = {{(`RVEX_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
        rvex_isa_pkg::rvex_alu_sltu:
          alu_result_o = {{(`RVEX_XLEN-1){1'b0}}, op_a < op_b};
        rvex_isa_pkg::rvex_alu_xor:  alu_result_o = op_a ^ op_b;
        rvex_isa_pkg::rvex_alu_srl:
          alu_result_o = alt_i ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
        rvex_isa_pkg::rvex_alu_or:   alu_result_o = op_a | op_b;
        rvex_isa_pkg::rvex_alu_and:  alu_result_o = op_a & op_b;
        default:                     alu_result_o = op_a + op_b;
      endcase
    end
  end

  assign lt_s = $signed(cmp_a) < $signed(cmp_b);
  assign lt_u = cmp_a < cmp_b;

  always_comb begin
    case (funct3_i)
      rvex_isa_pkg::rvex_f3_beq_c:  bru_result_o = cmp_a == cmp_b;
      rvex_isa_pkg::rvex_f3_bne_c:  bru_result_o = cmp_a != cmp_b;
      rvex_isa_pkg::rvex_f3_blt_c:  bru_result_o = lt_s;
      rvex_isa_pkg::rvex_f3_bge_c:  bru_result_o = ~lt_s;
      rvex_isa_pkg::rvex_f3_bltu_c: bru_result_o = lt_u;
      rvex_isa_pkg::rvex_f3_bgeu_c: bru_result_o = ~lt_u;
      default:                      bru_result_o = 1'b0;  // 010/011 not branches
    endcase
  end

endmodule : rvex_execute_dp

//--- rvex_execute_settings.svh
`ifndef RVEX_EXECUTE_SETTINGS_SVH
`define RVEX_EXECUTE_SETTINGS_SVH

// register data and pc width
`define RVEX_XLEN 32

// apb register block
`define RVEX_APB_AW 4

// event counter width, no wider than RVEX_XLEN
`define RVEX_CNT_W 32

`endif

//--- rvex_execute_stage.sv
`include "rvex_execute_settings.svh"

module rvex_execute_stage
  (input logic clk_i
   , input logic arst_n_i

   , input logic stall_i
   , input logic flush_i

   , input rvex_exec_pkg::rvex_execute_cword cword_i

   , input logic fwd_mem_rs1_v_i
   , input logic fwd_mem_rs2_v_i
   , input logic fwd_wb_rs1_v_i
   , input logic fwd_wb_rs2_v_i
   , input logic [`RVEX_XLEN-1:0] mem_rd_data_i
   , input logic [`RVEX_XLEN-1:0] wb_rd_data_i

   , output rvex_exec_pkg::rvex_memory_cword cword_o
   , output logic exec_evt_o
   , output logic redir_evt_o
   );

  rvex_exec_pkg::rvex_amux_sel_e amux_sel;
  rvex_exec_pkg::rvex_bmux_sel_e bmux_sel;
  logic [1:0] comp_a_sel;
  logic [1:0] comp_b_sel;
  logic add_override_v;
  logic load_nop;
  logic cword_w_v;
  logic [`RVEX_XLEN-1:0] alu_result;
  logic [`RVEX_XLEN-1:0] store_data;
  logic bru_result;
  rvex_exec_pkg::rvex_memory_cword cword_n;
  rvex_exec_pkg::rvex_memory_cword cword_r;

  rvex_execute_ctl u_ctl
    (.stall_i(stall_i)
     ,.flush_i(flush_i)
     ,.imm_v_i(cword_i.imm_v)
     ,.addpc_v_i(cword_i.addpc_v)
     ,.dmem_r_v_i(cword_i.dmem_r_v)
     ,.dmem_w_v_i(cword_i.dmem_w_v)
     ,.jmp_v_i(cword_i.jmp_v)
     ,.fwd_mem_rs1_v_i(fwd_mem_rs1_v_i)
     ,.fwd_mem_rs2_v_i(fwd_mem_rs2_v_i)
     ,.fwd_wb_rs1_v_i(fwd_wb_rs1_v_i)
     ,.fwd_wb_rs2_v_i(fwd_wb_rs2_v_i)
     ,.amux_sel_o(amux_sel)
     ,.bmux_sel_o(bmux_sel)
     ,.comp_a_sel_o(comp_a_sel)
     ,.comp_b_sel_o(comp_b_sel)
     ,.add_override_v_o(add_override_v)
     ,.load_nop_o(load_nop)
     ,.cword_w_v_o(cword_w_v)
     );

  rvex_execute_dp u_dp
    (.amux_sel_i(amux_sel)
     ,.bmux_sel_i(bmux_sel)
     ,.comp_a_sel_i(comp_a_sel)
     ,.comp_b_sel_i(comp_b_sel)
     ,.add_override_v_i(add_override_v)
     ,.funct3_i(cword_i.funct3)
     ,.alt_i(cword_i.alt)
     ,.pc_i(cword_i.pc)
     ,.imm_i(cword_i.imm)
     ,.rs1_data_i(cword_i.rs1_data)
     ,.rs2_data_i(cword_i.rs2_data)
     ,.mem_rd_data_i(mem_rd_data_i)
     ,.wb_rd_data_i(wb_rd_data_i)
     ,.alu_result_o(alu_result)
     ,.store_data_o(store_data)
     ,.bru_result_o(bru_result)
     );

  always_comb begin
    cword_n.valid      = cword_i.valid;
    cword_n.rd         = cword_i.rd;
    cword_n.rd_w_v     = cword_i.rd_w_v;
    cword_n.dmem_r_v   = cword_i.dmem_r_v;
    cword_n.dmem_w_v   = cword_i.dmem_w_v;
    cword_n.result     = alu_result;  // pc+imm on jumps and branches
    cword_n.store_data = store_data;
    cword_n.redirect_v = cword_i.valid & (cword_i.jmp_v | (cword_i.br_v & bru_result));
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cword_r <= '0;
    end else if (cword_w_v) begin
      cword_r <= load_nop ? '0 : cword_n;
    end
  end

  assign cword_o = cword_r;

  // one pulse per word actually captured
  assign exec_evt_o = cword_w_v & ~load_nop & cword_n.valid;
  assign redir_evt_o = cword_w_v & ~load_nop & cword_n.redirect_v;

  // decoded flags are exclusive
  a_cword_excl : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cword_i.valid |-> !(cword_i.br_v && cword_i.jmp_v)
                      && !(cword_i.dmem_r_v && cword_i.dmem_w_v));

endmodule : rvex_execute_stage

//--- rvex_execute_tb.sv
`include "rvex_execute_settings.svh"

module rvex_execute_tb;

  localparam logic [`RVEX_XLEN-1:0] mem_fwd_c = 'h50;  // memory stage rd value
  localparam logic [`RVEX_XLEN-1:0] wb_fwd_c = 'h07;   // writeback stage rd value
  localparam logic [`RVEX_APB_AW-1:0] bad_addr_c = 'hc;
  localparam int apb_cycles_c = 40;  // reset, apb transfers and hold sequence

  // instruction flags: valid br jmp imm pc ld st rd
  localparam logic [7:0] op_alu = 8'h81;
  localparam logic [7:0] op_alui = 8'h91;
  localparam logic [7:0] op_ld = 8'h95;
  localparam logic [7:0] op_st = 8'h92;
  localparam logic [7:0] op_auipc = 8'h99;
  localparam logic [7:0] op_br = 8'hd8;
  localparam logic [7:0] op_jal = 8'hb9;
  localparam logic [7:0] op_jalr = 8'hb1;

  typedef struct packed {
    logic [7:0] flags;
    logic [2:0] f3;
    logic alt;
    logic [`RVEX_XLEN-1:0] pc;
    logic [`RVEX_XLEN-1:0] imm;
    logic [`RVEX_XLEN-1:0] rs1;
    logic [`RVEX_XLEN-1:0] rs2;
    logic [3:0] fwd;  // mem rs1, mem rs2, wb rs1, wb rs2
    logic [1:0] ctl;  // stall, flush
    logic [1:0] dc;   // random rs1, rs2
    logic [1:0] exp;  // valid, redirect
    logic [`RVEX_XLEN-1:0] exp_result;
    logic [`RVEX_XLEN-1:0] exp_store;
  } row_t;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic stall_i, flush_i;
  logic in_valid_i, in_alt_i;
  logic [`RVEX_XLEN-1:0] in_pc_i, in_imm_i, in_rs1_data_i, in_rs2_data_i;
  logic [4:0] in_rd_i;
  logic [2:0] in_funct3_i;
  logic in_br_v_i, in_jmp_v_i, in_imm_v_i, in_addpc_v_i;
  logic in_dmem_r_v_i, in_dmem_w_v_i, in_rd_w_v_i;
  logic fwd_mem_rs1_v_i, fwd_mem_rs2_v_i, fwd_wb_rs1_v_i, fwd_wb_rs2_v_i;
  logic [`RVEX_XLEN-1:0] mem_rd_data_i, wb_rd_data_i;
  logic mem_valid_o, mem_rd_w_v_o, mem_dmem_r_v_o, mem_dmem_w_v_o;
  logic [4:0] mem_rd_o;
  logic [`RVEX_XLEN-1:0] mem_result_o, mem_store_data_o, redirect_pc_o;
  logic redirect_v_o;
  logic psel_i, penable_i, pwrite_i;
  logic [`RVEX_APB_AW-1:0] paddr_i;
  logic [`RVEX_XLEN-1:0] pwdata_i, prdata_o;
  logic pready_o, pslverr_o;

  row_t table_q[$];
  int n_errors = 0;
  int n_checks = 0;
  int cycles = 0;
  int cycle_limit = 1000;
  int exp_exec = 0;
  int exp_redir = 0;
  logic [4:0] exp_rd = '0;
  logic [2:0] exp_mem_flags = '0;  // rd write, load, store

  rvex_execute_top u_rvex_execute_top (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("%0d checks, %0d errors", n_checks, n_errors);
      $display("Errors found");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #10;
  endtask

  task automatic compare_word(input string name, input logic [`RVEX_XLEN-1:0] got,
                              input logic [`RVEX_XLEN-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [7:0] flags, input logic [2:0] f3, input logic alt,
                         input logic [`RVEX_XLEN-1:0] pc, input logic [`RVEX_XLEN-1:0] imm,
                         input logic [`RVEX_XLEN-1:0] rs1, input logic [`RVEX_XLEN-1:0] rs2,
                         input logic [3:0] fwd, input logic [1:0] ctl, input logic [1:0] dc,
                         input logic [1:0] exp, input logic [`RVEX_XLEN-1:0] res,
                         input logic [`RVEX_XLEN-1:0] st);
    table_q.push_back('{flags, f3, alt, pc, imm, rs1, rs2, fwd, ctl, dc, exp, res, st});
  endtask

  task automatic drive_row(input row_t r);
    {in_valid_i, in_br_v_i, in_jmp_v_i, in_imm_v_i} = r.flags[7:4];
    {in_addpc_v_i, in_dmem_r_v_i, in_dmem_w_v_i, in_rd_w_v_i} = r.flags[3:0];
    in_rd_i = 5'($urandom);
    in_funct3_i = r.f3;
    in_alt_i = r.alt;
    in_pc_i = r.pc;
    in_imm_i = r.imm;
    in_rs1_data_i = r.dc[1] ? $urandom : r.rs1;  // value must not matter
    in_rs2_data_i = r.dc[0] ? $urandom : r.rs2;
    {fwd_mem_rs1_v_i, fwd_mem_rs2_v_i, fwd_wb_rs1_v_i, fwd_wb_rs2_v_i} = r.fwd;
    {stall_i, flush_i} = r.ctl;
  endtask

  task automatic drive_idle();
    drive_row('0);
  endtask

  task automatic check_row(input row_t r);
    compare_word("mem_valid_o", mem_valid_o, r.exp[1]);
    compare_word("redirect_v_o", redirect_v_o, r.exp[0]);
    compare_word("mem_result_o", mem_result_o, r.exp_result);
    compare_word("mem_store_data_o", mem_store_data_o, r.exp_store);
    compare_word("mem_rd_o", mem_rd_o, exp_rd);
    compare_word("mem_rd_w_v_o", mem_rd_w_v_o, exp_mem_flags[2]);
    compare_word("mem_dmem_r_v_o", mem_dmem_r_v_o, exp_mem_flags[1]);
    compare_word("mem_dmem_w_v_o", mem_dmem_w_v_o, exp_mem_flags[0]);
    if (r.exp[0]) compare_word("redirect_pc_o", redirect_pc_o, r.exp_result);
  endtask

  // setup phase, access phase sampled just before the closing edge
  task automatic apb_write(input logic [`RVEX_APB_AW-1:0] addr,
                           input logic [`RVEX_XLEN-1:0] data, input logic exp_err);
    psel_i = 1'b1;
    pwrite_i = 1'b1;
    paddr_i = addr;
    pwdata_i = data;
    tick();
    penable_i = 1'b1;
    #80;
    compare_word("pready_o", pready_o, 1);
    compare_word("pslverr_o", pslverr_o, exp_err);
    tick();
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
  endtask

  task automatic apb_read(input logic [`RVEX_APB_AW-1:0] addr,
                          input logic [`RVEX_XLEN-1:0] exp_data, input logic exp_err);
    psel_i = 1'b1;
    pwrite_i = 1'b0;
    paddr_i = addr;
    tick();
    penable_i = 1'b1;
    #80;
    compare_word("pready_o", pready_o, 1);
    compare_word("pslverr_o", pslverr_o, exp_err);
    if (!exp_err) compare_word("prdata_o", prdata_o, exp_data);
    tick();
    psel_i = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic build_table();
    // op, funct3, alt, pc, imm, rs1, rs2, fwd, stall/flush, random rs1/rs2,
    // expected {valid, redirect}, result, store data
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 5, 3, 4'b0000, 2'b00, 2'b00, 2'b10, 8, 3);
    add_row(op_alu, 3'd0, 1'b1, 0, 0, 5, 3, 4'b0000, 2'b00, 2'b00, 2'b10, 2, 3);
    add_row(op_alu, 3'd0, 1'b1, 0, 0, 3, 5, 4'b0000, 2'b00, 2'b00, 2'b10, 'hffff_fffe, 5);
    add_row(op_alu, 3'd1, 1'b0, 0, 0, 1, 'h24, 4'b0000, 2'b00, 2'b00, 2'b10, 'h10, 'h24);
    add_row(op_alu, 3'd2, 1'b0, 0, 0, 'hffff_ffff, 1, 4'b0000, 2'b00, 2'b00, 2'b10, 1, 1);
    add_row(op_alu, 3'd3, 1'b0, 0, 0, 'hffff_ffff, 1, 4'b0000, 2'b00, 2'b00, 2'b10, 0, 1);
    add_row(op_alui, 3'd4, 1'b0, 0, 'hf0, 'hff, 'h123, 4'b0000, 2'b00, 2'b00, 2'b10, 'hf, 'h123);
    add_row(op_alu, 3'd5, 1'b0, 0, 0, 'h8000_0000, 4, 4'b0000, 2'b00, 2'b00, 2'b10,
            'h0800_0000, 4);
    add_row(op_alu, 3'd5, 1'b1, 0, 0, 'h8000_0000, 4, 4'b0000, 2'b00, 2'b00, 2'b10,
            'hf800_0000, 4);
    add_row(op_alu, 3'd6, 1'b0, 0, 0, 'hf0, 'h0f, 4'b0000, 2'b00, 2'b00, 2'b10, 'hff, 'h0f);
    add_row(op_alu, 3'd7, 1'b0, 0, 0, 'hff, 'h3c, 4'b0000, 2'b00, 2'b00, 2'b10, 'h3c, 'h3c);
    // funct3 of slt/sltu must not leak into address and pc adds
    add_row(op_ld, 3'd2, 1'b0, 0, 'h10, 'h1000, 0, 4'b0000, 2'b00, 2'b00, 2'b10, 'h1010, 0);
    add_row(op_st, 3'd2, 1'b0, 0, 8, 'h2000, 'hcafe, 4'b0000, 2'b00, 2'b00, 2'b10, 'h2008, 'hcafe);
    add_row(op_auipc, 3'd3, 1'b0, 'h100, 'h2000, 0, 0, 4'b0000, 2'b00, 2'b10, 2'b10, 'h2100, 0);
    // forwarding
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 0, 0, 4'b1111, 2'b00, 2'b11, 2'b10, 'ha0, 'h50);
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 0, 0, 4'b0011, 2'b00, 2'b11, 2'b10, 'he, 7);
    add_row(op_alu, 3'd0, 1'b1, 0, 0, 0, 0, 4'b1001, 2'b00, 2'b11, 2'b10, 'h49, 7);
    add_row(op_st, 3'd2, 1'b0, 0, 4, 'h300, 0, 4'b0001, 2'b00, 2'b01, 2'b10, 'h304, 7);
    // branches and jumps
    add_row(op_br, 3'd0, 1'b0, 'h400, 'h40, 9, 9, 4'b0000, 2'b00, 2'b00, 2'b11, 'h440, 9);
    add_row(op_br, 3'd1, 1'b0, 'h404, 'h20, 9, 9, 4'b0000, 2'b00, 2'b00, 2'b10, 'h424, 9);
    add_row(op_br, 3'd4, 1'b0, 'h500, 'hffff_fff0, 'hffff_fff0, 1, 4'b0000, 2'b00, 2'b00,
            2'b11, 'h4f0, 1);
    add_row(op_br, 3'd6, 1'b0, 'h500, 8, 'hffff_fff0, 1, 4'b0000, 2'b00, 2'b00, 2'b10, 'h508, 1);
    add_row(op_br, 3'd5, 1'b0, 'h10, 'h600, 0, 0, 4'b1001, 2'b00, 2'b11, 2'b11, 'h610, 7);
    add_row(op_br, 3'd7, 1'b0, 'h700, 4, 3, 'h8000_0000, 4'b0000, 2'b00, 2'b00, 2'b10,
            'h704, 'h8000_0000);
    add_row(op_jal, 3'd0, 1'b0, 'h800, 'h100, 0, 0, 4'b0000, 2'b00, 2'b10, 2'b11, 'h900, 0);
    add_row(op_jalr, 3'd0, 1'b0, 0, 'h10, 'h1234, 0, 4'b0000, 2'b00, 2'b00, 2'b11, 'h1244, 0);
    add_row(op_br & ~8'h80, 3'd0, 1'b0, 'h10, 'h10, 1, 1, 4'b0000, 2'b00, 2'b00, 2'b00, 'h20, 1);
    // stall, flush, both
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 'h11, 'h22, 4'b0000, 2'b00, 2'b00, 2'b10, 'h33, 'h22);
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 0, 0, 4'b0000, 2'b10, 2'b11, 2'b10, 'h33, 'h22);
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 1, 2, 4'b0000, 2'b01, 2'b00, 2'b00, 0, 0);
    add_row(op_jal, 3'd0, 1'b0, 'h40, 'h40, 0, 0, 4'b0000, 2'b00, 2'b10, 2'b11, 'h80, 0);
    add_row(op_alu, 3'd0, 1'b0, 0, 0, 0, 0, 4'b0000, 2'b11, 2'b11, 2'b00, 0, 0);
  endtask

  initial begin
    void'($urandom(52));
    arst_n_i = 1'b0;
    drive_idle();
    mem_rd_data_i = mem_fwd_c;
    wb_rd_data_i = wb_fwd_c;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    build_table();
    cycle_limit = table_q.size() * 2 + apb_cycles_c + 50;

    repeat (5) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;
    compare_word("mem_valid_o", mem_valid_o, 0);
    compare_word("redirect_v_o", redirect_v_o, 0);
    apb_read(rvex_exec_pkg::rvex_csr_exec_cnt_c, 0, 1'b0);
    apb_read(rvex_exec_pkg::rvex_csr_redir_cnt_c, 0, 1'b0);

    drive_row(table_q[0]);
    for (int i = 0; i < table_q.size(); i++) begin
      tick();
      if (table_q[i].ctl[0]) begin  // flush clears the whole word
        exp_rd = '0;
        exp_mem_flags = '0;
      end else if (!table_q[i].ctl[1]) begin
        exp_rd = in_rd_i;
        exp_mem_flags = {table_q[i].flags[0], table_q[i].flags[2], table_q[i].flags[1]};
      end
      check_row(table_q[i]);
      if (table_q[i].flags[7] && table_q[i].ctl == 2'b00) exp_exec++;  // word captured
      if (table_q[i].exp[0] && table_q[i].ctl == 2'b00) exp_redir++;
      if (i + 1 < table_q.size()) drive_row(table_q[i + 1]);
      else drive_idle();
    end
    apb_read(rvex_exec_pkg::rvex_csr_exec_cnt_c, exp_exec, 1'b0);
    apb_read(rvex_exec_pkg::rvex_csr_redir_cnt_c, exp_redir, 1'b0);

    // hold freezes the register like a stall
    in_valid_i = 1'b1;
    in_rd_w_v_i = 1'b1;
    in_rs1_data_i = 1;
    in_rs2_data_i = 2;
    tick();
    compare_word("mem_result_o", mem_result_o, 3);
    exp_exec++;
    stall_i = 1'b1;
    in_rs1_data_i = 5;
    in_rs2_data_i = 5;
    apb_write(rvex_exec_pkg::rvex_csr_ctrl_c, 1, 1'b0);
    stall_i = 1'b0;
    tick();
    compare_word("mem_valid_o", mem_valid_o, 1);
    compare_word("mem_result_o", mem_result_o, 3);
    apb_read(rvex_exec_pkg::rvex_csr_ctrl_c, 1, 1'b0);
    apb_write(rvex_exec_pkg::rvex_csr_ctrl_c, 0, 1'b0);
    tick();
    compare_word("mem_result_o", mem_result_o, 'ha);
    exp_exec++;
    drive_idle();

    apb_read(rvex_exec_pkg::rvex_csr_exec_cnt_c, exp_exec, 1'b0);
    apb_write(rvex_exec_pkg::rvex_csr_exec_cnt_c, 0, 1'b0);
    apb_read(rvex_exec_pkg::rvex_csr_exec_cnt_c, 0, 1'b0);
    apb_read(rvex_exec_pkg::rvex_csr_redir_cnt_c, exp_redir, 1'b0);
    apb_write(rvex_exec_pkg::rvex_csr_redir_cnt_c, 0, 1'b0);
    apb_read(rvex_exec_pkg::rvex_csr_redir_cnt_c, 0, 1'b0);
    apb_read(bad_addr_c, 0, 1'b1);
    apb_write(bad_addr_c, 'hffff_ffff, 1'b1);

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : rvex_execute_tb

//--- rvex_execute_top.sv
`include "rvex_execute_settings.svh"

module rvex_execute_top
  (input logic clk_i
   , input logic arst_n_i

   , input logic stall_i
   , input logic flush_i

   , input logic in_valid_i
   , input logic [`RVEX_XLEN-1:0] in_pc_i
   , input logic [4:0] in_rd_i
   , input logic [2:0] in_funct3_i
   , input logic in_alt_i
   , input logic [`RVEX_XLEN-1:0] in_imm_i
   , input logic [`RVEX_XLEN-1:0] in_rs1_data_i
   , input logic [`RVEX_XLEN-1:0] in_rs2_data_i
   , input logic in_br_v_i
   , input logic in_jmp_v_i
   , input logic in_imm_v_i
   , input logic in_addpc_v_i
   , input logic in_dmem_r_v_i
   , input logic in_dmem_w_v_i
   , input logic in_rd_w_v_i

   , input logic fwd_mem_rs1_v_i
   , input logic fwd_mem_rs2_v_i
   , input logic fwd_wb_rs1_v_i
   , input logic fwd_wb_rs2_v_i
   , input logic [`RVEX_XLEN-1:0] mem_rd_data_i
   , input logic [`RVEX_XLEN-1:0] wb_rd_data_i

   , output logic mem_valid_o
   , output logic [4:0] mem_rd_o
   , output logic mem_rd_w_v_o
   , output logic mem_dmem_r_v_o
   , output logic mem_dmem_w_v_o
   , output logic [`RVEX_XLEN-1:0] mem_result_o
   , output logic [`RVEX_XLEN-1:0] mem_store_data_o
   , output logic redirect_v_o
   , output logic [`RVEX_XLEN-1:0] redirect_pc_o

   , input logic psel_i
   , input logic penable_i
   , input logic pwrite_i
   , input logic [`RVEX_APB_AW-1:0] paddr_i
   , input logic [`RVEX_XLEN-1:0] pwdata_i
   , output logic [`RVEX_XLEN-1:0] prdata_o
   , output logic pready_o
   , output logic pslverr_o
   );

  rvex_exec_pkg::rvex_execute_cword ex_cword;
  rvex_exec_pkg::rvex_memory_cword mem_cword;
  logic hold;
  logic exec_evt;
  logic redir_evt;

  assign ex_cword = '{valid: in_valid_i, br_v: in_br_v_i, jmp_v: in_jmp_v_i,
                      imm_v: in_imm_v_i, addpc_v: in_addpc_v_i,
                      dmem_r_v: in_dmem_r_v_i, dmem_w_v: in_dmem_w_v_i,
                      rd_w_v: in_rd_w_v_i, pc: in_pc_i, rd: in_rd_i,
                      funct3: in_funct3_i, alt: in_alt_i, imm: in_imm_i,
                      rs1_data: in_rs1_data_i, rs2_data: in_rs2_data_i};

  rvex_execute_stage u_rvex_execute_stage
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.stall_i(stall_i | hold)  // hold freezes like a stall
     ,.flush_i(flush_i)
     ,.cword_i(ex_cword)
     ,.fwd_mem_rs1_v_i(fwd_mem_rs1_v_i)
     ,.fwd_mem_rs2_v_i(fwd_mem_rs2_v_i)
     ,.fwd_wb_rs1_v_i(fwd_wb_rs1_v_i)
     ,.fwd_wb_rs2_v_i(fwd_wb_rs2_v_i)
     ,.mem_rd_data_i(mem_rd_data_i)
     ,.wb_rd_data_i(wb_rd_data_i)
     ,.cword_o(mem_cword)
     ,.exec_evt_o(exec_evt)
     ,.redir_evt_o(redir_evt)
     );

  rvex_exec_csr u_rvex_exec_csr
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.psel_i(psel_i)
     ,.penable_i(penable_i)
     ,.pwrite_i(pwrite_i)
     ,.paddr_i(paddr_i)
     ,.pwdata_i(pwdata_i)
     ,.prdata_o(prdata_o)
     ,.pready_o(pready_o)
     ,.pslverr_o(pslverr_o)
     ,.hold_o(hold)
     ,.exec_evt_i(exec_evt)
     ,.redir_evt_i(redir_evt)
     );

  assign mem_valid_o      = mem_cword.valid;
  assign mem_rd_o         = mem_cword.rd;
  assign mem_rd_w_v_o     = mem_cword.rd_w_v;
  assign mem_dmem_r_v_o   = mem_cword.dmem_r_v;
  assign mem_dmem_w_v_o   = mem_cword.dmem_w_v;
  assign mem_result_o     = mem_cword.result;
  assign mem_store_data_o = mem_cword.store_data;
  assign redirect_v_o     = mem_cword.redirect_v;
  assign redirect_pc_o    = mem_cword.result;

endmodule : rvex_execute_top

//--- rvex_isa_pkg.sv
package rvex_isa_pkg;

  // op / op-imm funct3
  localparam logic [2:0] rvex_f3_add_sub_c = 3'b000;
  localparam logic [2:0] rvex_f3_sll_c     = 3'b001;
  localparam logic [2:0] rvex_f3_slt_c     = 3'b010;
  localparam logic [2:0] rvex_f3_sltu_c    = 3'b011;
  localparam logic [2:0] rvex_f3_xor_c     = 3'b100;
  localparam logic [2:0] rvex_f3_srl_sra_c = 3'b101;
  localparam logic [2:0] rvex_f3_or_c      = 3'b110;
  localparam logic [2:0] rvex_f3_and_c     = 3'b111;

  // branch funct3
  localparam logic [2:0] rvex_f3_beq_c  = 3'b000;
  localparam logic [2:0] rvex_f3_bne_c  = 3'b001;
  localparam logic [2:0] rvex_f3_blt_c  = 3'b100;
  localparam logic [2:0] rvex_f3_bge_c  = 3'b101;
  localparam logic [2:0] rvex_f3_bltu_c = 3'b110;
  localparam logic [2:0] rvex_f3_bgeu_c = 3'b111;

  // alu op is funct3, alt bit picks sub / sra
  typedef enum logic [2:0] {
    rvex_alu_add  = rvex_f3_add_sub_c,
    rvex_alu_sll  = rvex_f3_sll_c,
    rvex_alu_slt  = rvex_f3_slt_c,
    rvex_alu_sltu = rvex_f3_sltu_c,
    rvex_alu_xor  = rvex_f3_xor_c,
    rvex_alu_srl  = rvex_f3_srl_sra_c,
    rvex_alu_or   = rvex_f3_or_c,
    rvex_alu_and  = rvex_f3_and_c
  } rvex_alu_op_e;

endpackage : rvex_isa_pkg
